/* rtl/heap_config.svh */
/*
  Heap array memory sizing
  Array count, element geometry and credit depths shared by RTL and bench
*/
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// ---------------------------------------------------------------------
// Array geometry
// ---------------------------------------------------------------------
`define HEAP_ARRAY_BITS 3        // 8 arrays
`define HEAP_INDEX_BITS 3        // 8 elements per array
`define HEAP_DATA_BITS 16        // Element width

// ---------------------------------------------------------------------
// Flow control
// ---------------------------------------------------------------------
`define HEAP_CMD_CREDITS 4       // Command FIFO depth and sender start credit
`define HEAP_RSP_CREDIT_BITS 3   // Response credit counter width

`endif

/* rtl/heapPkg.sv */
/*
  Heap array memory types
  Opcodes, status codes and the structs passed between pipeline stages
*/
`include "heap_config.svh"

package heapPkg;

  typedef enum logic [3:0] {
    opAlloc,
    opFree,
    opWrite,
    opRead,
    opSize,
    opPush,
    opPop,
    opAdd,
    opAddAfter,
    opXor
  } heapOp_t;

  typedef enum logic [2:0] {
    statusOk,
    statusNotAllocated,
    statusOutOfBounds,
    statusFull,
    statusEmpty,
    statusNoMemory
  } heapStatus_t;

  typedef enum logic [1:0] {
    aluNone,
    aluAdd,
    aluXor
  } heapAlu_t;

  typedef enum logic [2:0] {
    selInput,                                     // Echo command value
    selElem,                                      // Element, old or new
    selSize,                                      // Size after the operation
    selArray,                                     // Allocated array number
    selZero
  } heapRspSel_t;

  typedef struct packed {
    heapOp_t                      op;
    logic [`HEAP_ARRAY_BITS-1:0]  array;
    logic [`HEAP_INDEX_BITS-1:0]  index;
    logic [`HEAP_DATA_BITS-1:0]   value;
  } heapCmd_t;

  typedef struct packed {
    logic                         needsAlloc;     // Array must be allocated
    logic                         needsBounds;    // Index must be below size
    logic                         isAlloc;
    logic                         isFree;
    logic                         writesElem;
    logic                         grows;          // Push
    logic                         shrinks;        // Pop
    heapAlu_t                     aluKind;
    logic                         returnsOld;
    heapRspSel_t                  rspSel;
    logic [`HEAP_ARRAY_BITS-1:0]  array;
    logic [`HEAP_INDEX_BITS-1:0]  index;
    logic [`HEAP_DATA_BITS-1:0]   value;
  } heapCtl_t;

  typedef struct packed {
    heapStatus_t                  status;
    logic [`HEAP_DATA_BITS-1:0]   value;
  } heapRsp_t;

endpackage

/* rtl/cmdQueue.sv */
/*
  Command queue
  Circular FIFO ahead of decode, returns a sender credit per drained entry
*/
`include "heap_config.svh"

module cmdQueue (
  input  logic              clock,
  input  logic              resetN,
  input  logic              inValid,
  input  heapPkg::heapCmd_t inCmd,
  output logic              outValid,
  output heapPkg::heapCmd_t outCmd,
  input  logic              outTaken,
  output logic              credit
);
  import heapPkg::*;

  localparam int Depth   = `HEAP_CMD_CREDITS;
  localparam int PtrBits = $clog2(Depth);

  heapCmd_t           entries [Depth];
  logic [PtrBits-1:0] wrPtr;
  logic [PtrBits-1:0] rdPtr;
  logic [PtrBits:0]   count;

  always_ff @(posedge clock) begin
    if (inValid) begin
      entries[wrPtr] <= inCmd;                    // Sender never exceeds its credit
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (inValid) begin
        wrPtr <= (wrPtr == PtrBits'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (outTaken) begin
        rdPtr <= (rdPtr == PtrBits'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({inValid, outTaken})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit <= outTaken;                         // One pulse per drained entry
    end
  end

  assign outValid = (count != '0);
  assign outCmd   = entries[rdPtr];

endmodule

/* rtl/opDecode.sv */
/*
  Opcode decode stage
  Maps each opcode to control flags and registers them for execute
*/
module opDecode (
  input  logic              clock,
  input  logic              resetN,
  input  logic              inValid,
  input  heapPkg::heapCmd_t inCmd,
  output logic              inTaken,
  output logic              outValid,
  output heapPkg::heapCtl_t outCtl,
  input  logic              outTaken
);
  import heapPkg::*;

  heapCtl_t ctlNext;

  always_comb begin
    ctlNext         = '0;
    ctlNext.aluKind = aluNone;
    ctlNext.rspSel  = selZero;
    ctlNext.array   = inCmd.array;
    ctlNext.index   = inCmd.index;
    ctlNext.value   = inCmd.value;
    case (inCmd.op)
      opAlloc: begin
        ctlNext.isAlloc    = 1'b1;
        ctlNext.rspSel     = selArray;
      end
      opFree: begin
        ctlNext.needsAlloc = 1'b1;
        ctlNext.isFree     = 1'b1;
      end
      opWrite: begin
        ctlNext.needsAlloc = 1'b1;
        ctlNext.writesElem = 1'b1;                // Size raised to index+1
        ctlNext.rspSel     = selInput;
      end
      opRead: begin
        ctlNext.needsAlloc  = 1'b1;
        ctlNext.needsBounds = 1'b1;
        ctlNext.returnsOld  = 1'b1;
        ctlNext.rspSel      = selElem;
      end
      opSize: begin
        ctlNext.needsAlloc = 1'b1;
        ctlNext.rspSel     = selSize;
      end
      opPush: begin
        ctlNext.needsAlloc = 1'b1;
        ctlNext.writesElem = 1'b1;
        ctlNext.grows      = 1'b1;
        ctlNext.rspSel     = selSize;             // New size
      end
      opPop: begin
        ctlNext.needsAlloc = 1'b1;
        ctlNext.shrinks    = 1'b1;
        ctlNext.returnsOld = 1'b1;
        ctlNext.rspSel     = selElem;
      end
      opAdd, opAddAfter, opXor: begin
        ctlNext.needsAlloc  = 1'b1;
        ctlNext.needsBounds = 1'b1;
        ctlNext.writesElem  = 1'b1;
        ctlNext.aluKind     = (inCmd.op == opXor) ? aluXor : aluAdd;
        ctlNext.returnsOld  = (inCmd.op == opAddAfter);
        ctlNext.rspSel      = selElem;
      end
      default: ;                                  // Unknown opcode answers zero
    endcase
  end

  assign inTaken = inValid && (!outValid || outTaken);

  always_ff @(posedge clock) begin
    if (inTaken) begin
      outCtl <= ctlNext;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      outValid <= 1'b0;
    end else if (inTaken) begin
      outValid <= 1'b1;
    end else if (outTaken) begin
      outValid <= 1'b0;
    end
  end

endmodule

/* rtl/heapExecute.sv */
/*
  Heap execute stage
  Holds the arrays, sizes and allocator, checks each command and applies it
*/
module heapExecute #(
  parameter int ArrayBits = 3,
  parameter int IndexBits = 3,
  parameter int DataBits  = 16
) (
  input  logic              clock,
  input  logic              resetN,
  input  logic              inValid,
  input  heapPkg::heapCtl_t inCtl,
  output logic              inTaken,
  output logic              outValid,
  output heapPkg::heapRsp_t outRsp,
  input  logic              outTaken
);
  import heapPkg::*;

  localparam int Arrays   = 1 << ArrayBits;
  localparam int Length   = 1 << IndexBits;
  localparam int SizeBits = IndexBits + 1;

  logic [DataBits-1:0]            elems     [Arrays*Length];
  logic [SizeBits-1:0]            sizes     [Arrays];
  logic [ArrayBits-1:0]           freeStack [Arrays];
  logic [Arrays-1:0]              allocated;
  logic [ArrayBits:0]             freeTop;
  logic [ArrayBits:0]             freeTopLess;
  logic [ArrayBits:0]             freshCount;   // Next never-used array

  heapStatus_t                    status;
  logic                           doUpdate;
  logic                           noneLeft;
  logic [ArrayBits-1:0]           allocArray;
  logic [SizeBits-1:0]            sizeNow;
  logic [SizeBits-1:0]            sizeLess;
  logic [SizeBits-1:0]            sizeNext;
  logic [SizeBits-1:0]            indexPlusOne;
  logic [IndexBits-1:0]           elemIdx;
  logic [ArrayBits+IndexBits-1:0] elemAddr;
  logic [DataBits-1:0]            oldElem;
  logic [DataBits-1:0]            newElem;
  logic [DataBits-1:0]            rspValue;

  // ---------------------------------------------------------------------
  // Operand lookup
  // ---------------------------------------------------------------------
  assign sizeNow      = sizes[inCtl.array];
  assign sizeLess     = sizeNow - 1'b1;
  assign indexPlusOne = {1'b0, inCtl.index} + 1'b1;
  assign freeTopLess  = freeTop - 1'b1;
  assign noneLeft     = (freeTop == '0) && freshCount[ArrayBits];
  assign allocArray   = (freeTop != '0) ? freeStack[freeTopLess[ArrayBits-1:0]]
                                        : freshCount[ArrayBits-1:0];   // Reuse freed first

  always_comb begin
    if (inCtl.grows) begin
      elemIdx = sizeNow[IndexBits-1:0];           // Push slot
    end else if (inCtl.shrinks) begin
      elemIdx = sizeLess[IndexBits-1:0];          // Top element
    end else begin
      elemIdx = inCtl.index;
    end
  end

  assign elemAddr = {inCtl.array, elemIdx};
  assign oldElem  = elems[elemAddr];

  always_comb begin
    case (inCtl.aluKind)
      aluAdd:  newElem = oldElem + inCtl.value;   // Wraps modulo 2^16
      aluXor:  newElem = oldElem ^ inCtl.value;
      default: newElem = inCtl.value;
    endcase
  end

  // ---------------------------------------------------------------------
  // Checks, in priority order
  // ---------------------------------------------------------------------
  always_comb begin
    if (inCtl.needsAlloc && !allocated[inCtl.array]) begin
      status = statusNotAllocated;
    end else if (inCtl.needsBounds && ({1'b0, inCtl.index} >= sizeNow)) begin
      status = statusOutOfBounds;
    end else if (inCtl.grows && sizeNow[IndexBits]) begin
      status = statusFull;
    end else if (inCtl.isAlloc && noneLeft) begin
      status = statusNoMemory;
    end else if (inCtl.shrinks && (sizeNow == '0)) begin
      status = statusEmpty;
    end else begin
      status = statusOk;
    end
  end

  always_comb begin
    if (inCtl.grows) begin
      sizeNext = sizeNow + 1'b1;
    end else if (inCtl.shrinks) begin
      sizeNext = sizeLess;
    end else if (inCtl.writesElem && (indexPlusOne > sizeNow)) begin
      sizeNext = indexPlusOne;
    end else begin
      sizeNext = sizeNow;
    end
  end

  always_comb begin
    case (inCtl.rspSel)
      selInput: rspValue = inCtl.value;
      selElem:  rspValue = inCtl.returnsOld ? oldElem : newElem;
      selSize:  rspValue = DataBits'(sizeNext);
      selArray: rspValue = DataBits'(allocArray);
      default:  rspValue = '0;
    endcase
    if (status != statusOk) begin
      rspValue = '0;                              // Errors carry no value
    end
  end

  assign inTaken  = inValid && (!outValid || outTaken);
  assign doUpdate = inTaken && (status == statusOk);

  // ---------------------------------------------------------------------
  // State updates
  // ---------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (doUpdate && inCtl.writesElem) begin
      elems[elemAddr] <= newElem;
    end
    if (doUpdate && inCtl.isAlloc) begin
      sizes[allocArray] <= '0;                    // Fresh array starts empty
    end else if (doUpdate) begin
      sizes[inCtl.array] <= sizeNext;
    end
    if (doUpdate && inCtl.isFree) begin
      freeStack[freeTop[ArrayBits-1:0]] <= inCtl.array;
    end
    if (inTaken) begin
      outRsp.status <= status;
      outRsp.value  <= rspValue;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      outValid   <= 1'b0;
      allocated  <= '0;
      freeTop    <= '0;
      freshCount <= '0;
    end else begin
      if (inTaken) begin
        outValid <= 1'b1;
      end else if (outTaken) begin
        outValid <= 1'b0;
      end
      if (doUpdate && inCtl.isAlloc) begin
        allocated[allocArray] <= 1'b1;
        if (freeTop != '0) begin
          freeTop <= freeTopLess;
        end else begin
          freshCount <= freshCount + 1'b1;
        end
      end
      if (doUpdate && inCtl.isFree) begin
        allocated[inCtl.array] <= 1'b0;           // Own flag, so a second free fails
        freeTop                <= freeTop + 1'b1;
      end
    end
  end

endmodule

/* rtl/rspStage.sv */
/*
  Response stage
  Holds one response and emits it only while the consumer has granted credit
*/
module rspStage #(
  parameter int CreditBits = 3
) (
  input  logic              clock,
  input  logic              resetN,
  input  logic              inValid,
  input  heapPkg::heapRsp_t inRsp,
  output logic              inTaken,
  input  logic              rspCredit,
  output logic              rspValid,
  output heapPkg::heapRsp_t rsp
);

  logic                  held;                   // Response register occupied
  logic [CreditBits-1:0] credits;

  assign rspValid = held && (credits != '0);
  assign inTaken  = inValid && (!held || rspValid);

  always_ff @(posedge clock) begin
    if (inTaken) begin
      rsp <= inRsp;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      held    <= 1'b0;
      credits <= '0;                             // Consumer grants after reset
    end else begin
      if (inTaken) begin
        held <= 1'b1;
      end else if (rspValid) begin
        held <= 1'b0;
      end
      case ({rspCredit, rspValid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;             // Grant and spend cancel
      endcase
    end
  end

endmodule

/* rtl/heapTop.sv */
/*
  Heap array memory top
  Command queue, decode, execute and response stages under credit flow control
*/
`include "heap_config.svh"

module heapTop (
  input  logic              clock,
  input  logic              resetN,
  input  logic              cmdValid,
  input  heapPkg::heapCmd_t cmd,
  output logic              cmdCredit,
  input  logic              rspCredit,
  output logic              rspValid,
  output heapPkg::heapRsp_t rsp
);
  import heapPkg::*;

  logic     queueValid;
  heapCmd_t queueCmd;
  logic     decodeTaken;
  logic     ctlValid;
  heapCtl_t ctl;
  logic     execTaken;
  logic     resValid;
  heapRsp_t res;
  logic     rspTaken;

  cmdQueue u_cmdQueue (
    .clock    (clock),
    .resetN   (resetN),
    .inValid  (cmdValid),
    .inCmd    (cmd),
    .outValid (queueValid),
    .outCmd   (queueCmd),
    .outTaken (decodeTaken),
    .credit   (cmdCredit)
  );

  opDecode u_opDecode (
    .clock    (clock),
    .resetN   (resetN),
    .inValid  (queueValid),
    .inCmd    (queueCmd),
    .inTaken  (decodeTaken),
    .outValid (ctlValid),
    .outCtl   (ctl),
    .outTaken (execTaken)
  );

  heapExecute #(
    .ArrayBits (`HEAP_ARRAY_BITS),
    .IndexBits (`HEAP_INDEX_BITS),
    .DataBits  (`HEAP_DATA_BITS)
  ) u_heapExecute (
    .clock    (clock),
    .resetN   (resetN),
    .inValid  (ctlValid),
    .inCtl    (ctl),
    .inTaken  (execTaken),
    .outValid (resValid),
    .outRsp   (res),
    .outTaken (rspTaken)
  );

  rspStage #(
    .CreditBits (`HEAP_RSP_CREDIT_BITS)
  ) u_rspStage (
    .clock     (clock),
    .resetN    (resetN),
    .inValid   (resValid),
    .inRsp     (res),
    .inTaken   (rspTaken),
    .rspCredit (rspCredit),
    .rspValid  (rspValid),
    .rsp       (rsp)
  );

endmodule

/* bench/heapTb.sv */
/*
  Heap array memory testbench
  LFSR driven commands against a reference model, checked by assertions
*/
`include "heap_config.svh"

module heapTb;
  import heapPkg::*;

  localparam int Arrays     = 1 << `HEAP_ARRAY_BITS;
  localparam int Length     = 1 << `HEAP_INDEX_BITS;
  localparam int DataBits   = `HEAP_DATA_BITS;
  localparam int CmdCredits = `HEAP_CMD_CREDITS;
  localparam int WaitLimit  = 2000;              // Cycles per wait loop

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayNum_t;
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIdx_t;
  typedef logic [DataBits-1:0]         word_t;

  logic     clock = 1'b0;
  logic     resetN = 1'b0;
  logic     cmdValid = 1'b0;
  heapCmd_t cmd = '0;
  logic     cmdCredit;
  logic     rspCredit = 1'b0;
  logic     rspValid;
  heapRsp_t rsp;

  logic [31:0] lfsrState = 32'd69249;
  int          senderCredit = CmdCredits;
  int          cmdsSent = 0;
  int          creditsReturned = 0;
  int          rspHeld = 0;                      // Granted, not yet used
  int          creditMode = 0;                   // 0 stall, 1 random gaps, 2 every cycle
  heapRsp_t    expQ [$];
  heapRsp_t    expFront = '0;
  int          expCount = 0;

  // Reference model state
  word_t       refMem [Arrays][Length];
  int          refSize [Arrays];
  logic        refAlloc [Arrays];
  int          refFree [Arrays];
  int          refFreeTop = 0;
  int          refFresh = 0;

  heapTop u_heapTop (
    .clock     (clock),
    .resetN    (resetN),
    .cmdValid  (cmdValid),
    .cmd       (cmd),
    .cmdCredit (cmdCredit),
    .rspCredit (rspCredit),
    .rspValid  (rspValid),
    .rsp       (rsp)
  );

  always #5 clock = ~clock;

  // ---------------------------------------------------------------------
  // Failure reporting and random bits
  // ---------------------------------------------------------------------
  task automatic stopRun();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
    stopRun();
  endtask

  task automatic reportFailure(input string what);
    $display("Error: %s", what);
    stopRun();
  endtask

  function automatic logic randomBit();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
      lfsrState = lfsrState ^ 32'hA300_0000;     // Taps 32, 30, 26, 25
    end
    return outBit;
  endfunction

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits = {bits[30:0], randomBit()};
    end
    return bits;
  endfunction

  // ---------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------
  task automatic predict(input heapCmd_t c, output heapRsp_t r);
    int    arr;
    int    idx;
    int    sz;
    int    slot;
    word_t old;
    arr      = c.array;
    idx      = c.index;
    sz       = refSize[arr];
    old      = refMem[arr][idx];
    r.status = statusOk;
    r.value  = '0;
    if (c.op != opAlloc && !refAlloc[arr]) begin
      r.status = statusNotAllocated;
    end else if ((c.op inside {opRead, opAdd, opAddAfter, opXor}) && idx >= sz) begin
      r.status = statusOutOfBounds;
    end else if (c.op == opPush && sz == Length) begin
      r.status = statusFull;
    end else if (c.op == opAlloc && refFreeTop == 0 && refFresh == Arrays) begin
      r.status = statusNoMemory;
    end else if (c.op == opPop && sz == 0) begin
      r.status = statusEmpty;
    end else begin
      case (c.op)
        opAlloc: begin
          if (refFreeTop > 0) begin                // Most recently freed first
            refFreeTop--;
            slot = refFree[refFreeTop];
          end else begin
            slot = refFresh;
            refFresh++;
          end
          refAlloc[slot] = 1'b1;
          refSize[slot]  = 0;
          r.value        = word_t'(slot);
        end
        opFree: begin
          refFree[refFreeTop] = arr;
          refFreeTop++;
          refAlloc[arr] = 1'b0;
        end
        opWrite: begin
          refMem[arr][idx] = c.value;
          if (idx + 1 > sz) begin
            refSize[arr] = idx + 1;
          end
          r.value = c.value;
        end
        opRead:  r.value = old;
        opSize:  r.value = word_t'(sz);
        opPush: begin
          refMem[arr][sz] = c.value;
          refSize[arr]    = sz + 1;
          r.value         = word_t'(sz + 1);
        end
        opPop: begin
          refSize[arr] = sz - 1;
          r.value      = refMem[arr][sz-1];
        end
        opAdd: begin
          refMem[arr][idx] = old + c.value;
          r.value          = old + c.value;
        end
        opAddAfter: begin
          refMem[arr][idx] = old + c.value;
          r.value          = old;
        end
        opXor: begin
          refMem[arr][idx] = old ^ c.value;
          r.value          = old ^ c.value;
        end
        default: ;
      endcase
    end
  endtask

  function automatic void refreshFront();
    expCount = expQ.size();
    expFront = (expCount > 0) ? expQ[0] : '0;
  endfunction

  // ---------------------------------------------------------------------
  // Clocking, sender and consumer
  // ---------------------------------------------------------------------
  task automatic tick();
    @(posedge clock);
    #1;
    rspCredit = 1'b0;
    if (rspHeld < 7 && (creditMode == 2 || (creditMode == 1 && randomBit()))) begin
      rspCredit = 1'b1;                          // Stay within the 3-bit DUT counter
      rspHeld++;
    end
  endtask

  task automatic sendCmd(input heapOp_t op, input int arr, input int idx, input word_t val);
    heapCmd_t c;
    heapRsp_t r;
    int       waited;
    waited = 0;
    while (senderCredit == 0 && waited < WaitLimit) begin
      tick();
      waited++;
    end
    if (senderCredit == 0) begin
      reportFailure("timed out waiting for a command credit");
    end else begin
      c.op    = op;
      c.array = arrayNum_t'(arr);
      c.index = elemIdx_t'(idx);
      c.value = val;
      predict(c, r);
      expQ.push_back(r);
      refreshFront();
      cmd      = c;
      cmdValid = 1'b1;
      senderCredit--;
      cmdsSent++;
      tick();
      cmdValid = 1'b0;
    end
  endtask

  task automatic sendRandom();
    heapOp_t op;
    int      arr;
    int      idx;
    op  = heapOp_t'(randomBits(4) % 10);
    arr = int'(randomBits(`HEAP_ARRAY_BITS));
    idx = int'(randomBits(`HEAP_INDEX_BITS));
    sendCmd(op, arr, idx, word_t'(randomBits(DataBits)));
  endtask

  task automatic waitDrain();
    int waited;
    waited = 0;
    while ((expCount != 0 || senderCredit != CmdCredits) && waited < WaitLimit) begin
      tick();
      waited++;
    end
    if (expCount != 0 || senderCredit != CmdCredits) begin
      reportFailure("timed out waiting for the pipeline to drain");
    end
  endtask

  // Response and credit bookkeeping, sampled before the edge updates
  always @(posedge clock) begin
    if (resetN) begin
      if (cmdCredit) begin
        senderCredit++;
        creditsReturned++;
      end
      if (rspValid) begin
        rspHeld--;
        if (expQ.size() > 0) begin
          void'(expQ.pop_front());
        end
        refreshFront();
      end
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  assert property (@(posedge clock) disable iff (!resetN) rspValid |-> expCount > 0)
    else reportFailure("response arrived with no command outstanding");
  assert property (@(posedge clock) disable iff (!resetN)
                   rspValid |-> rsp.status == expFront.status)
    else reportMismatch("rsp.status", $sampled(rsp.status), $sampled(expFront.status));
  assert property (@(posedge clock) disable iff (!resetN)
                   rspValid |-> rsp.value == expFront.value)
    else reportMismatch("rsp.value", $sampled(rsp.value), $sampled(expFront.value));
  assert property (@(posedge clock) disable iff (!resetN) rspValid |-> rspHeld > 0)
    else reportFailure("rspValid high with no response credit granted");
  assert property (@(posedge clock) disable iff (!resetN)
                   cmdCredit |-> creditsReturned < cmdsSent)
    else reportFailure("more command credits returned than commands sent");

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  initial begin
    for (int a = 0; a < Arrays; a++) begin
      refSize[a]  = 0;
      refAlloc[a] = 1'b0;
      refFree[a]  = 0;
      for (int e = 0; e < Length; e++) begin
        refMem[a][e] = '0;
      end
    end
    repeat (16) @(posedge clock);
    #1;
    resetN     = 1'b1;
    creditMode = 2;

    for (int a = 0; a <= Arrays; a++) begin
      sendCmd(opAlloc, 0, 0, '0);                // Last one has no memory left
    end
    for (int a = 0; a < Arrays; a++) begin
      for (int e = 0; e < Length; e++) begin
        sendCmd(opPush, a, 0, word_t'(randomBits(DataBits)));
      end
    end
    sendCmd(opPush, 0, 0, 16'h0bad);             // Full
    for (int e = 0; e <= Length; e++) begin
      sendCmd(opPop, 7, 0, '0);                  // Reverse order, then empty
    end

    sendCmd(opFree, 3, 0, '0);
    sendCmd(opFree, 5, 0, '0);
    sendCmd(opAlloc, 0, 0, '0);
    sendCmd(opAlloc, 0, 0, '0);
    sendCmd(opFree, 2, 0, '0);
    sendCmd(opFree, 2, 0, '0);                   // Double free
    sendCmd(opRead, 2, 0, '0);
    sendCmd(opAlloc, 0, 0, '0);

    sendCmd(opWrite, 2, 4, 16'h1234);
    sendCmd(opRead, 2, 4, '0);
    sendCmd(opSize, 2, 0, '0);
    sendCmd(opRead, 2, 5, '0);                   // Past the size
    sendCmd(opAdd, 2, 4, 16'hf00f);              // Wraps
    sendCmd(opAddAfter, 2, 4, 16'h0ff1);
    sendCmd(opXor, 2, 4, 16'haaaa);
    waitDrain();

    creditMode = 1;
    repeat (400) sendRandom();
    creditMode = 2;
    waitDrain();

    // Back-pressure until the sender runs dry
    creditMode = 0;
    for (int i = 0; i < 40; i++) begin
      if (senderCredit > 0) begin
        sendRandom();
      end else begin
        tick();
      end
    end
    if (senderCredit != 0) begin
      reportFailure("sender kept command credit while responses were stalled");
    end
    creditMode = 2;
    waitDrain();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* list.f */
+incdir+rtl
rtl/heapPkg.sv
rtl/cmdQueue.sv
rtl/opDecode.sv
rtl/heapExecute.sv
rtl/rspStage.sv
rtl/heapTop.sv
bench/heapTb.sv

/* run.sh */
#!/bin/sh
# Builds the heap memory testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module heapTb -o heapSim

# The simulation exits non-zero on $fatal, so the log decides the result
./obj_dir/heapSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
